//--- tests/afu_done_golden.txt
# operand  length  expected_return  item_count  odd_count, all hex
# return is the 64-bit sum of operand+i for i below length, each item wraps in 32 bits
00000000 0001 0000000000000000 00000001 00000000
00000001 0001 0000000000000001 00000001 00000001
00000005 0004 000000000000001a 00000004 00000002
00000010 0010 0000000000000178 00000010 00000008
fffffffe 0004 00000001fffffffe 00000004 00000002
fffffff0 0020 0000000ffffffff0 00000020 00000010
80000000 0003 0000000180000003 00000003 00000001
12345678 0005 000000005b05b062 00000005 00000002
7fffffff 0002 00000000ffffffff 00000002 00000001
ffffffff 0001 00000000ffffffff 00000001 00000001
00000003 0064 0000000000001482 00000064 00000032
ffffff00 012c 000000ffffff8332 0000012c 00000096
00000002 0007 0000000000000023 00000007 00000003
fffffffd 0006 00000002fffffffd 00000006 00000003
0000abcd 0002 000000000001579b 00000002 00000001
00000000 0040 00000000000007e0 00000040 00000020

//--- sim.f
logic/afu_done_pkg.sv
logic/job_engine.sv
logic/done_control.sv
logic/soft_reset_seq.sv
logic/mmio_done_port.sv
logic/afu_done_top.sv
tests/tb_clock_gen.sv
tests/tb_afu_done.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
# Build the testbench with Verilator, then run it and look for the pass line
verilator --binary --timing --assert --top-module tb_afu_done -f sim.f -o sim_afu_done || exit 1
sim_out=$(./obj_dir/sim_afu_done)
echo "$sim_out"
echo "$sim_out" | grep -q "Simulation finished: PASS" && exit 0 || exit 1

//--- tests/tb_afu_done.sv
`timescale 1ns/10ps

module tb_afu_done;

	localparam int SOFT_RESET_CYCLES = 4;
	localparam int CLOCK_PERIOD_NS   = 4;
	localparam int STALL_CYCLES      = 8;

	logic                       clock;
	logic                       rstn;
	logic                       enabled;
	logic                       job_req;
	afu_done_pkg::job_t         job;
	logic                       job_ack;
	logic                       done_req;
	afu_done_pkg::done_report_t done_data;
	logic                       done_ack;

	// Golden columns, one entry per job
	logic [31:0] gold_operand[$];
	logic [15:0] gold_length[$];
	logic [63:0] gold_return[$];
	logic [31:0] gold_items[$];
	logic [31:0] gold_odds[$];

	logic [31:0]                rand_state;
	int                         reports_seen;
	logic                       prev_job_req;
	logic                       prev_job_ack;
	logic                       prev_done_req;
	logic                       prev_done_ack;
	afu_done_pkg::done_report_t prev_done_data;
	longint                     watchdog_ns;
	logic                       watchdog_armed = 1'b0;

	tb_clock_gen clock_gen (
		.clock (clock),
		.rstn  (rstn)
	);

	afu_done_top #(
		.SOFT_RESET_CYCLES (SOFT_RESET_CYCLES)
	) UUT (
		.clock     (clock),
		.rstn      (rstn),
		.enabled   (enabled),
		.job_req   (job_req),
		.job       (job),
		.job_ack   (job_ack),
		.done_req  (done_req),
		.done_data (done_data),
		.done_ack  (done_ack)
	);

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	// One xorshift32 step
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Simulation finished: FAIL");
		$fatal(1, "run aborted");
	endtask

	task automatic report_mismatch(input string msg);
		abort_run($sformatf("ERR at %0t ns: %s", $time, msg));
	endtask

	// Inputs move 1 ns after the edge, outputs read there too
	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	task automatic load_golden();
		int          fd;
		int          n;
		string       line;
		logic [31:0] op;
		logic [31:0] len;
		logic [63:0] ret;
		logic [31:0] items;
		logic [31:0] odds;
		fd = $fopen("tests/afu_done_golden.txt", "r");
		if (fd == 0)
			abort_run("Could not open the golden file tests/afu_done_golden.txt");
		while ($fgets(line, fd) != 0) begin
			// Skip blank and comment lines
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			n = $sscanf(line, "%h %h %h %h %h", op, len, ret, items, odds);
			if (n != 5)
				abort_run({"Malformed line in the golden file: ", line});
			gold_operand.push_back(op);
			gold_length.push_back(len[15:0]);
			gold_return.push_back(ret);
			gold_items.push_back(items);
			gold_odds.push_back(odds);
		end
		$fclose(fd);
		if (gold_operand.size() == 0)
			abort_run("The golden file holds no jobs");
	endtask

	////////////////////////////////////////
	// One job, start to done report
	////////////////////////////////////////

	task automatic run_job(input int idx);
		int delay;
		// Job request, held until ack
		job.operand = gold_operand[idx];
		job.length  = gold_length[idx];
		job_req     = 1'b1;
		while (!job_ack)
			next_cycle();
		job_req = 1'b0;
		while (job_ack)
			next_cycle();
		// Some jobs see the controller stalled
		if (idx % 3 != 0) begin
			// Late start puts the stall on the soft reset request
			if (idx % 3 == 2)
				repeat (int'(gold_length[idx])) next_cycle();
			enabled = 1'b0;
			repeat (STALL_CYCLES) next_cycle();
			enabled = 1'b1;
		end
		while (!done_req)
			next_cycle();
		assert (done_data.valid) else
			report_mismatch($sformatf("job %0d report not valid", idx));
		assert (done_data.value == gold_return[idx]) else
			report_mismatch($sformatf("job %0d return %h, expected %h",
				idx, done_data.value, gold_return[idx]));
		assert (done_data.stats.item_count == gold_items[idx]) else
			report_mismatch($sformatf("job %0d item count %0d, expected %0d",
				idx, done_data.stats.item_count, gold_items[idx]));
		assert (done_data.stats.odd_count == gold_odds[idx]) else
			report_mismatch($sformatf("job %0d odd count %0d, expected %0d",
				idx, done_data.stats.odd_count, gold_odds[idx]));
		// Host answers late, 0 to 7 cycles
		rand_state = xorshift32(rand_state);
		delay      = int'(rand_state % 32'd8);
		repeat (delay) next_cycle();
		done_ack = 1'b1;
		while (done_req)
			next_cycle();
		done_ack = 1'b0;
		assert (reports_seen == idx + 1) else
			report_mismatch($sformatf("after job %0d saw %0d reports", idx, reports_seen));
	endtask

	////////////////////////////////////////
	// Handshake monitor
	////////////////////////////////////////

	// Mid cycle sampling, away from both edges
	// Host levels from the previous sample are what the DUT saw at the edge
	always @(negedge clock) begin
		if (rstn) begin
			if (job_ack && !prev_job_ack) begin
				assert (prev_job_req) else
					report_mismatch("job_ack rose without job_req");
			end
			if (!job_ack && prev_job_ack) begin
				assert (!prev_job_req) else
					report_mismatch("job_ack fell while job_req still high");
			end
			if (done_req && !prev_done_req) begin
				assert (!prev_done_ack) else
					report_mismatch("done_req rose before done_ack fell");
				reports_seen++;
			end
			if (done_req && prev_done_req) begin
				assert (done_data == prev_done_data) else
					report_mismatch("done_data changed while done_req held");
			end
			if (!done_req && prev_done_req) begin
				assert (prev_done_ack) else
					report_mismatch("done_req fell without done_ack");
			end
		end
		prev_job_req   = job_req;
		prev_job_ack   = job_ack;
		prev_done_req  = done_req;
		prev_done_ack  = done_ack;
		prev_done_data = done_data;
	end

	// Watchdog
	initial begin
		wait (watchdog_armed);
		#(watchdog_ns);
		abort_run($sformatf("Timeout: the run did not finish within %0d ns", watchdog_ns));
	end

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		longint budget;
		enabled        = 1'b1;
		job_req        = 1'b0;
		job            = '0;
		done_ack       = 1'b0;
		rand_state     = 32'd14485;
		reports_seen   = 0;
		prev_job_req   = 1'b0;
		prev_job_ack   = 1'b0;
		prev_done_req  = 1'b0;
		prev_done_ack  = 1'b0;
		prev_done_data = '0;
		load_golden();
		// Limit scales with job lengths
		budget = 0;
		for (int i = 0; i < gold_length.size(); i++)
			budget += longint'(gold_length[i]) + SOFT_RESET_CYCLES + 30;
		watchdog_ns    = budget * CLOCK_PERIOD_NS;
		watchdog_armed = 1'b1;
		@(posedge rstn);
		next_cycle();
		assert (!job_ack && !done_req && !done_data.valid) else
			report_mismatch("outputs not idle after reset");
		for (int i = 0; i < gold_operand.size(); i++)
			run_job(i);
		// Quiet tail, no stray report
		repeat (20) next_cycle();
		assert (reports_seen == gold_operand.size()) else
			report_mismatch($sformatf("%0d reports for %0d jobs",
				reports_seen, gold_operand.size()));
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
	output logic clock,
	output logic rstn
);

	// 4 ns period
	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// Reset held for 16 cycles, released off the edge
	initial begin
		rstn = 1'b0;
		repeat (16) @(posedge clock);
		#1;
		rstn = 1'b1;
	end

endmodule

//--- logic/afu_done_top.sv
`timescale 1ns/10ps

module afu_done_top #(
	parameter int SOFT_RESET_CYCLES = 4
) (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       enabled,
	input  logic                       job_req,
	input  afu_done_pkg::job_t         job,
	output logic                       job_ack,
	output logic                       done_req,
	output afu_done_pkg::done_report_t done_data,
	input  logic                       done_ack
);

	logic                          soft_rstn;
	logic [63:0]                   cu_return;
	afu_done_pkg::response_stats_t response_stats;
	logic                          cu_done;
	logic                          reset_done;
	logic                          cu_return_done_ack;
	afu_done_pkg::done_report_t    report;

	////////////////////////////////////////
	// Compute unit
	////////////////////////////////////////

	job_engine u_job_engine (
		.clock          (clock),
		.rstn           (rstn),
		.soft_rstn      (soft_rstn),
		.job_req        (job_req),
		.job            (job),
		.job_ack        (job_ack),
		.cu_return      (cu_return),
		.response_stats (response_stats),
		.cu_done        (cu_done)
	);

	////////////////////////////////////////
	// Completion path
	////////////////////////////////////////

	done_control u_done_control (
		.clock              (clock),
		.rstn               (rstn),
		.soft_rstn          (soft_rstn),
		.enabled            (enabled),
		.cu_return          (cu_return),
		.response_stats     (response_stats),
		.cu_done            (cu_done),
		.cu_return_done_ack (cu_return_done_ack),
		.reset_done         (reset_done),
		.report             (report)
	);

	// Soft reset pulse for the engine
	soft_reset_seq #(
		.SOFT_RESET_CYCLES (SOFT_RESET_CYCLES)
	) u_soft_reset_seq (
		.clock      (clock),
		.rstn       (rstn),
		.reset_done (reset_done),
		.soft_rstn  (soft_rstn)
	);

	// Host facing done port
	mmio_done_port u_mmio_done_port (
		.clock              (clock),
		.rstn               (rstn),
		.report             (report),
		.done_ack           (done_ack),
		.cu_return_done_ack (cu_return_done_ack),
		.done_req           (done_req),
		.done_data          (done_data)
	);

endmodule

//--- logic/mmio_done_port.sv
`timescale 1ns/10ps

module mmio_done_port (
	input  logic                       clock,
	input  logic                       rstn,
	input  afu_done_pkg::done_report_t report,
	input  logic                       done_ack,
	output logic                       cu_return_done_ack,
	output logic                       done_req,
	output afu_done_pkg::done_report_t done_data
);

	// Host side handshake phases
	typedef enum logic [1:0] {
		PORT_IDLE,
		PORT_REQ,
		PORT_ACK_LOW
	} port_state_t;

	port_state_t state;

	////////////////////////////////////////
	// Four phase done handshake
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state              <= PORT_IDLE;
			done_req           <= 1'b0;
			done_data          <= '0;
			cu_return_done_ack <= 1'b0;
		end else begin
			// Ack to controller is a single pulse
			cu_return_done_ack <= 1'b0;
			case (state)
				PORT_IDLE: begin
					// Take a snapshot of the report
					if (report.valid) begin
						done_data <= report;
						done_req  <= 1'b1;
						state     <= PORT_REQ;
					end
				end
				PORT_REQ: begin
					// Data stays put until the host answers
					if (done_ack) begin
						done_req           <= 1'b0;
						done_data.valid    <= 1'b0;
						cu_return_done_ack <= 1'b1;
						state              <= PORT_ACK_LOW;
					end
				end
				PORT_ACK_LOW: begin
					// Host must close the handshake first
					if (!done_ack)
						state <= PORT_IDLE;
				end
				default: state <= PORT_IDLE;
			endcase
		end
	end

endmodule

//--- logic/soft_reset_seq.sv
`timescale 1ns/10ps

module soft_reset_seq #(
	parameter int SOFT_RESET_CYCLES = 4
) (
	input  logic clock,
	input  logic rstn,
	input  logic reset_done,
	output logic soft_rstn
);

	localparam int CNT_W = (SOFT_RESET_CYCLES > 1) ? $clog2(SOFT_RESET_CYCLES) : 1;

	logic             reset_done_q;
	logic             request;
	logic [CNT_W-1:0] remaining;

	////////////////////////////////////////
	// Request detect
	////////////////////////////////////////

	// Falling edge of reset_done is one request
	assign request = reset_done_q && !reset_done;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			reset_done_q <= 1'b1;
		else
			reset_done_q <= reset_done;
	end

	////////////////////////////////////////
	// Pulse counter
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			soft_rstn <= 1'b1;
			remaining <= '0;
		end else if (soft_rstn) begin
			// Start the low phase
			if (request) begin
				soft_rstn <= 1'b0;
				remaining <= CNT_W'(SOFT_RESET_CYCLES - 1);
			end
		end else begin
			// Busy, new requests are dropped
			if (remaining == '0)
				soft_rstn <= 1'b1;
			else
				remaining <= remaining - 1'b1;
		end
	end

endmodule

//--- logic/done_control.sv
`timescale 1ns/10ps

module done_control (
	input  logic                          clock,
	input  logic                          rstn,
	input  logic                          soft_rstn,
	input  logic                          enabled,
	input  logic [63:0]                   cu_return,
	input  afu_done_pkg::response_stats_t response_stats,
	input  logic                          cu_done,
	input  logic                          cu_return_done_ack,
	output logic                          reset_done,
	output afu_done_pkg::done_report_t    report
);

	afu_done_pkg::done_state_t     state;
	afu_done_pkg::done_state_t     next_state;
	logic                          enabled_q;
	logic                          soft_rstn_s1;
	logic                          soft_rstn_s2;
	logic                          soft_rstn_rise;
	logic                          rise_seen;
	logic                          ack_seen;
	logic [63:0]                   value_latched;
	afu_done_pkg::response_stats_t stats_latched;

	////////////////////////////////////////
	// Soft reset release detect
	////////////////////////////////////////

	// Two flop sync, then edge register
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			soft_rstn_s1   <= 1'b1;
			soft_rstn_s2   <= 1'b1;
			soft_rstn_rise <= 1'b0;
		end else begin
			soft_rstn_s1   <= soft_rstn;
			soft_rstn_s2   <= soft_rstn_s1;
			soft_rstn_rise <= soft_rstn_s1 && !soft_rstn_s2;
		end
	end

	////////////////////////////////////////
	// Enable and sticky events
	////////////////////////////////////////

	// Events are kept while the FSM is stalled so none slips by
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled_q <= 1'b0;
			rise_seen <= 1'b0;
			ack_seen  <= 1'b0;
		end else begin
			enabled_q <= enabled;
			// Cleared in idle before the next request
			if (state == afu_done_pkg::DONE_IDLE)
				rise_seen <= 1'b0;
			else if (soft_rstn_rise)
				rise_seen <= 1'b1;
			// Cleared once back in idle
			if (state == afu_done_pkg::DONE_IDLE)
				ack_seen <= 1'b0;
			else if (cu_return_done_ack)
				ack_seen <= 1'b1;
		end
	end

	////////////////////////////////////////
	// Completion FSM
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			state <= afu_done_pkg::DONE_RESET;
		else if (enabled_q)
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			afu_done_pkg::DONE_RESET: begin
				next_state = afu_done_pkg::DONE_IDLE;
			end
			afu_done_pkg::DONE_IDLE: begin
				if (cu_done)
					next_state = afu_done_pkg::DONE_RESET_REQ;
			end
			afu_done_pkg::DONE_RESET_REQ: begin
				next_state = afu_done_pkg::DONE_RESET_PENDING;
			end
			afu_done_pkg::DONE_RESET_PENDING: begin
				// Engine is clean again
				if (soft_rstn_rise || rise_seen)
					next_state = afu_done_pkg::DONE_MMIO_REQ;
			end
			afu_done_pkg::DONE_MMIO_REQ: begin
				if (cu_return_done_ack || ack_seen)
					next_state = afu_done_pkg::DONE_IDLE;
			end
			default: next_state = afu_done_pkg::DONE_RESET;
		endcase
	end

	// Track engine output until done, then hold it
	always_ff @(posedge clock) begin
		if (state == afu_done_pkg::DONE_IDLE) begin
			value_latched <= cu_return;
			stats_latched <= response_stats;
		end
	end

	////////////////////////////////////////
	// Outputs
	////////////////////////////////////////

	// Request pulse for the reset sequencer
	assign reset_done = (state != afu_done_pkg::DONE_RESET_REQ);

	// Report withdrawn as soon as the port has taken it
	assign report.valid = (state == afu_done_pkg::DONE_MMIO_REQ) && !ack_seen;
	assign report.value = report.valid ? value_latched : 64'b0;
	assign report.stats = report.valid ? stats_latched : '0;

endmodule

//--- logic/job_engine.sv
`timescale 1ns/10ps

module job_engine (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         soft_rstn,
	input  logic                         job_req,
	input  afu_done_pkg::job_t           job,
	output logic                         job_ack,
	output logic [63:0]                  cu_return,
	output afu_done_pkg::response_stats_t response_stats,
	output logic                         cu_done
);

	// Engine phases
	typedef enum logic [1:0] {
		ENG_IDLE,
		ENG_RUN,
		ENG_DONE,
		ENG_ACK_RELEASE
	} eng_state_t;

	eng_state_t         state;
	logic               accept;
	logic               last_item;
	logic [15:0]        length_q;
	logic [31:0]        item_value;
	logic [31:0]        item_cnt;
	logic [31:0]        odd_cnt;
	logic [63:0]        sum;

	// New job only from idle, out of soft reset, on a fresh request
	assign accept    = (state == ENG_IDLE) && soft_rstn && job_req && !job_ack;
	assign last_item = (item_cnt + 32'd1) == {16'b0, length_q};

	////////////////////////////////////////
	// Job handshake
	////////////////////////////////////////

	// Ack rises on accept, falls only once the host drops its request
	// Soft reset leaves it alone so a held request is not taken twice
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_ack <= 1'b0;
		end else if (accept) begin
			job_ack <= 1'b1;
		end else if (!job_req) begin
			job_ack <= 1'b0;
		end
	end

	////////////////////////////////////////
	// Control and published results
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state          <= ENG_IDLE;
			cu_done        <= 1'b0;
			cu_return      <= 64'b0;
			response_stats <= '0;
		end else if (!soft_rstn) begin
			// Soft reset drops the finished job
			state          <= ENG_IDLE;
			cu_done        <= 1'b0;
			cu_return      <= 64'b0;
			response_stats <= '0;
		end else begin
			case (state)
				ENG_IDLE: begin
					if (accept)
						state <= ENG_RUN;
				end
				ENG_RUN: begin
					if (last_item)
						state <= ENG_DONE;
				end
				ENG_DONE: begin
					// Sum is final here, publish it
					cu_return                 <= sum;
					response_stats.item_count <= item_cnt;
					response_stats.odd_count  <= odd_cnt;
					cu_done                   <= 1'b1;
					state                     <= ENG_ACK_RELEASE;
				end
				ENG_ACK_RELEASE: begin
					// Hold done level until the controller soft resets us
					state <= ENG_ACK_RELEASE;
				end
				default: state <= ENG_IDLE;
			endcase
		end
	end

	////////////////////////////////////////
	// Item datapath
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (accept) begin
			length_q   <= job.length;
			item_value <= job.operand;
			item_cnt   <= 32'd0;
			odd_cnt    <= 32'd0;
			sum        <= 64'd0;
		end else if (state == ENG_RUN) begin
			// One item per cycle, value wraps in 32 bits
			sum        <= sum + {32'b0, item_value};
			odd_cnt    <= odd_cnt + {31'b0, item_value[0]};
			item_value <= item_value + 32'd1;
			item_cnt   <= item_cnt + 32'd1;
		end
	end

endmodule

//--- logic/afu_done_pkg.sv
package afu_done_pkg;

	////////////////////////////////////////
	// Job descriptor
	////////////////////////////////////////

	// Host job, one handshake per job
	typedef struct packed {
		// First item value, later items count up from here
		logic [31:0] operand;
		// Number of items, never zero
		logic [15:0] length;
	} job_t;

	////////////////////////////////////////
	// Engine statistics
	////////////////////////////////////////

	// Per-job response counters
	typedef struct packed {
		// Items walked by the engine
		logic [31:0] item_count;
		// Items with bit 0 set
		logic [31:0] odd_count;
	} response_stats_t;

	////////////////////////////////////////
	// Host done report
	////////////////////////////////////////

	// Completion record offered to the host
	typedef struct packed {
		// Report present
		logic            valid;
		// CU return value
		logic [63:0]     value;
		// Counters of the finished job
		response_stats_t stats;
	} done_report_t;

	////////////////////////////////////////
	// Completion FSM states
	////////////////////////////////////////

	typedef enum logic [2:0] {
		// Leaving reset
		DONE_RESET         = 3'd0,
		// Tracking engine results
		DONE_IDLE          = 3'd1,
		// One cycle soft reset request
		DONE_RESET_REQ     = 3'd2,
		// Waiting for soft reset release
		DONE_RESET_PENDING = 3'd3,
		// Report offered to the host port
		DONE_MMIO_REQ      = 3'd4
	} done_state_t;

endpackage
